//--- all.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_lq_entry.sv
verilog/lsu_lq_select.sv
verilog/lsu_lq.sv
verification/lsu_lq_checker.sv
verification/lsu_lq_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the load queue testbench with Verilator and runs it, exit status follows the result
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f all.f --top-module lsu_lq_tb -o lsu_lq_sim; then
    echo "build failed"
    exit 1
fi

./obj_dir/lsu_lq_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi

if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

//--- verification/lsu_lq_tb.sv
// Load queue testbench top, drives the six directed tests and reports the overall result
`default_nettype none

`include "lsu_params.svh"

module lsu_lq_tb;

    localparam int PERIOD = 4;
    // Rough cycle budget of reset and the six tests, then a margin on top
    localparam int TEST_CYCLES = 8 + 16 + 8 + 20 + 12 + 30 + 16;
    localparam int MARGIN = 60;

    logic                                clk;
    logic                                reset;
    logic                                flush;
    logic                                stall;
    lsu_pkg::lq_alloc_t                  alloc;
    lsu_pkg::lq_update_t                 update;
    lsu_pkg::mhq_fill_t                  fill;
    lsu_pkg::sq_retire_t                 sq;
    lsu_pkg::rob_retire_t                rob;
    logic                                full;
    logic [`LSU_LQ_IDX_WIDTH-1:0]        alloc_idx;
    lsu_pkg::lq_replay_t                 replay;
    logic [`LSU_LQ_IDX_WIDTH-1:0]        replay_idx;
    logic                                retire_ack;
    logic                                retire_misspec;
    int                                  errors;
    int                                  checks;
    int                                  tests_run;
    logic [31:0]                         lfsr;

    lsu_lq dut0 (
        .clk(clk), .i_reset(reset), .i_flush(flush), .i_alloc(alloc), .i_update(update),
        .i_mhq_fill(fill), .i_sq_retire(sq), .i_rob_retire(rob), .i_replay_stall(stall),
        .o_full(full), .o_alloc_idx(alloc_idx), .o_replay(replay), .o_replay_idx(replay_idx),
        .o_retire_ack(retire_ack), .o_retire_misspeculated(retire_misspec)
    );

    lsu_lq_checker chk0 (
        .clk(clk), .i_reset(reset), .i_flush(flush), .i_alloc(alloc), .i_update(update),
        .i_mhq_fill(fill), .i_sq_retire(sq), .i_rob_retire(rob), .i_replay_stall(stall),
        .i_full(full), .i_alloc_idx(alloc_idx), .i_replay(replay), .i_replay_idx(replay_idx),
        .i_retire_ack(retire_ack), .i_retire_misspec(retire_misspec),
        .o_errors(errors), .o_checks(checks)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Galois LFSR, one step per random bit
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic clear_inputs();
        alloc  = '0;
        update = '0;
        fill   = '0;
        sq     = '0;
        rob    = '0;
        flush  = 1'b0;
    endtask

    // Holds the driven values for one cycle, then drops the request enables
    task automatic step();
        @(negedge clk);
        clear_inputs();
    endtask

    task automatic idle(int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic alloc_load(logic [4:0] tag, logic [31:0] addr);
        logic [31:0] r;
        r = take_bits(3) % 32'd5;
        alloc.en   = 1'b1;
        alloc.func = lsu_pkg::lsu_func_t'(r[2:0]);
        alloc.tag  = tag;
        alloc.addr = addr;
        step();
    endtask

    task automatic set_update(logic [2:0] idx, logic retry, logic rpl, logic [1:0] mtag,
                              logic mretry, logic mreplay);
        update.en         = 1'b1;
        update.lq_idx     = idx;
        update.retry      = retry;
        update.replay     = rpl;
        update.mhq_tag    = mtag;
        update.mhq_retry  = mretry;
        update.mhq_replay = mreplay;
    endtask

    // Hit unless retry or replay is given
    task automatic do_update(logic [2:0] idx, logic retry, logic rpl, logic [1:0] mtag,
                             logic mretry);
        set_update(idx, retry, rpl, mtag, mretry, 1'b0);
        step();
    endtask

    task automatic fill_tag(logic [1:0] tag);
        fill.en  = 1'b1;
        fill.tag = tag;
        step();
    endtask

    task automatic retire_tag(logic [4:0] tag);
        rob.en  = 1'b1;
        rob.tag = tag;
        step();
    endtask

    task automatic store_range(logic [31:0] a, logic [31:0] a_end);
        sq.en       = 1'b1;
        sq.addr     = a;
        sq.addr_end = a_end;
        step();
    endtask

    task automatic flush_queue();
        flush = 1'b1;
        step();
    endtask

    task automatic report_test(string name, int errors_before);
        tests_run++;
        $display("test %s finished with %0d errors", name, errors - errors_before);
    endtask

    task automatic test_fill_queue();
        int e0;
        e0 = errors;
        for (int i = 0; i < 8; i++) alloc_load(5'(i + 8), take_bits(32));
        // Dropped while full
        alloc_load(5'd30, take_bits(32));
        do_update(3'd3, 1'b0, 1'b0, 2'd0, 1'b0);
        retire_tag(5'd11);
        alloc_load(5'd20, take_bits(32));
        // Slot 0 must still hold its own tag after the dropped request
        do_update(3'd0, 1'b0, 1'b0, 2'd0, 1'b0);
        retire_tag(5'd8);
        idle(1);
        flush_queue();
        report_test("fill_queue", e0);
    endtask

    task automatic test_hit_retire();
        int e0;
        e0 = errors;
        alloc_load(5'd4, take_bits(32));
        do_update(3'd0, 1'b0, 1'b0, 2'd0, 1'b0);
        retire_tag(5'd5);
        retire_tag(5'd4);
        idle(1);
        flush_queue();
        report_test("hit_retire", e0);
    endtask

    task automatic test_tag_wait();
        int e0;
        e0 = errors;
        for (int i = 0; i < 3; i++) alloc_load(5'(i + 1), take_bits(32));
        // Slot 0 waits on tag 2 and wakes after the pointer has moved past it
        do_update(3'd0, 1'b1, 1'b0, 2'd2, 1'b0);
        do_update(3'd1, 1'b1, 1'b0, 2'd1, 1'b0);
        do_update(3'd2, 1'b1, 1'b0, 2'd1, 1'b0);
        fill_tag(2'd3);
        idle(1);
        stall = 1'b1;
        fill_tag(2'd1);
        idle(2);
        // Slot 1 goes first, then slot 2 wins over slot 0 because the pointer sits at 2
        stall = 1'b0;
        fill_tag(2'd2);
        idle(3);
        flush_queue();
        report_test("tag_wait", e0);
    endtask

    task automatic test_any_fill();
        int e0;
        logic [31:0] r;
        e0 = errors;
        for (int i = 0; i < 3; i++) alloc_load(5'(i + 6), take_bits(32));
        do_update(3'd0, 1'b1, 1'b0, 2'd0, 1'b1);
        r = take_bits(2);
        fill_tag(r[1:0]);
        // Retry updates that meet a fill in the same cycle
        set_update(3'd1, 1'b1, 1'b0, 2'd0, 1'b1, 1'b0);
        fill.en  = 1'b1;
        fill.tag = 2'd3;
        step();
        set_update(3'd2, 1'b1, 1'b0, 2'd2, 1'b0, 1'b0);
        fill.en  = 1'b1;
        fill.tag = 2'd2;
        step();
        idle(4);
        flush_queue();
        report_test("any_fill", e0);
    endtask

    task automatic test_store_overlap();
        int e0;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] a4;
        e0 = errors;
        a4 = '0;
        // Loads packed into a small window so that stores often hit them
        for (int i = 0; i < 6; i++) begin
            r = take_bits(4);
            a = 32'h0000_2000 + r;
            if (i == 4) a4 = a;
            alloc_load(5'(i + 10), a);
        end
        for (int i = 0; i < 4; i++) do_update(3'(i), 1'b0, 1'b0, 2'd0, 1'b0);
        do_update(3'd4, 1'b1, 1'b0, 2'd0, 1'b1);
        for (int i = 0; i < 4; i++) begin
            r = take_bits(6);
            a = 32'h0000_2000 + 32'(r[3:0]);
            store_range(a, a + 32'(r[5:4]) + 32'd1);
        end
        for (int i = 0; i < 4; i++) retire_tag(5'(i + 10));
        // A store right on the parked load, whose flag must stay low while it waits
        store_range(a4, a4 + 32'd1);
        fill_tag(2'd0);
        idle(1);
        do_update(3'd4, 1'b0, 1'b0, 2'd0, 1'b0);
        do_update(3'd5, 1'b0, 1'b0, 2'd0, 1'b0);
        retire_tag(5'd14);
        retire_tag(5'd15);
        flush_queue();
        report_test("store_overlap", e0);
    endtask

    task automatic test_flush();
        int e0;
        e0 = errors;
        for (int i = 0; i < 8; i++) alloc_load(5'(i + 16), take_bits(32));
        do_update(3'd0, 1'b0, 1'b0, 2'd0, 1'b0);
        // Stall keeps slot 1 on offer until the flush
        stall = 1'b1;
        do_update(3'd1, 1'b0, 1'b1, 2'd0, 1'b0);
        idle(1);
        flush_queue();
        stall = 1'b0;
        idle(1);
        retire_tag(5'd16);
        idle(1);
        report_test("flush", e0);
    endtask

    initial begin
        lfsr      = 32'h0381_06f9;
        tests_run = 0;
        reset     = 1'b1;
        stall     = 1'b0;
        clear_inputs();
        repeat (8) @(negedge clk);
        reset = 1'b0;
        test_fill_queue();
        test_hit_retire();
        test_tag_wait();
        test_any_fill();
        test_store_overlap();
        test_flush();
        idle(2);
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((TEST_CYCLES + MARGIN) * PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/lsu_lq_checker.sv
// Load queue scoreboard, instantiated next to the DUT in the testbench to model every entry and compare
`default_nettype none

`include "lsu_params.svh"

module lsu_lq_checker (
    input  logic                            clk,
    input  logic                            i_reset,
    input  logic                            i_flush,
    input  lsu_pkg::lq_alloc_t              i_alloc,
    input  lsu_pkg::lq_update_t             i_update,
    input  lsu_pkg::mhq_fill_t              i_mhq_fill,
    input  lsu_pkg::sq_retire_t             i_sq_retire,
    input  lsu_pkg::rob_retire_t            i_rob_retire,
    input  logic                            i_replay_stall,
    input  logic                            i_full,
    input  logic [`LSU_LQ_IDX_WIDTH-1:0]    i_alloc_idx,
    input  lsu_pkg::lq_replay_t             i_replay,
    input  logic [`LSU_LQ_IDX_WIDTH-1:0]    i_replay_idx,
    input  logic                            i_retire_ack,
    input  logic                            i_retire_misspec,
    output int                              o_errors,
    output int                              o_checks
);

    localparam int DEPTH = `LSU_LQ_DEPTH;

    // Reference copy of every entry
    lsu_pkg::lq_state_t                 st [DEPTH];
    lsu_pkg::lsu_func_t                 fn [DEPTH];
    logic [`LSU_ROB_IDX_WIDTH-1:0]      tg [DEPTH];
    logic [`LSU_ADDR_WIDTH-1:0]         ad [DEPTH];
    logic [`LSU_MHQ_IDX_WIDTH-1:0]      mt [DEPTH];
    logic                               ms [DEPTH];
    int                                 ptr;

    // Bytes read by each load kind
    function automatic int load_bytes(lsu_pkg::lsu_func_t f);
        case (f)
            lsu_pkg::LSU_FUNC_LB, lsu_pkg::LSU_FUNC_LBU: return 1;
            lsu_pkg::LSU_FUNC_LH, lsu_pkg::LSU_FUNC_LHU: return 2;
            default: return 4;
        endcase
    endfunction

    // True when the retiring store writes any byte the load read
    function automatic logic hits_store(logic [31:0] a, lsu_pkg::lsu_func_t f,
                                        lsu_pkg::sq_retire_t s);
        logic [31:0] a_end;
        a_end = a + 32'(load_bytes(f));
        return s.en && ((a >= s.addr && a < s.addr_end) || (s.addr >= a && s.addr < a_end));
    endfunction

    // Next state of one entry from the queue rules
    function automatic lsu_pkg::lq_state_t step_state(lsu_pkg::lq_state_t s, logic alloc_hit,
            logic upd_hit, lsu_pkg::lq_update_t u, lsu_pkg::mhq_fill_t f,
            logic [1:0] wait_tag, logic grant, logic retire_hit, logic flush);
        if (flush) return lsu_pkg::LQ_STATE_INVALID;
        case (s)
            lsu_pkg::LQ_STATE_INVALID:
                return alloc_hit ? lsu_pkg::LQ_STATE_VALID : s;
            lsu_pkg::LQ_STATE_VALID, lsu_pkg::LQ_STATE_LAUNCHED: begin
                if (!upd_hit) return s;
                if (u.replay || u.mhq_replay) return lsu_pkg::LQ_STATE_REPLAYABLE;
                // Fill in the same cycle as the retry wakes the load straight away
                if (u.retry && u.mhq_retry)
                    return f.en ? lsu_pkg::LQ_STATE_REPLAYABLE : lsu_pkg::LQ_STATE_MHQ_FILL_WAIT;
                if (u.retry)
                    return (f.en && f.tag == u.mhq_tag) ? lsu_pkg::LQ_STATE_REPLAYABLE
                                                       : lsu_pkg::LQ_STATE_MHQ_TAG_WAIT;
                return lsu_pkg::LQ_STATE_COMPLETE;
            end
            lsu_pkg::LQ_STATE_MHQ_TAG_WAIT:
                return (f.en && f.tag == wait_tag) ? lsu_pkg::LQ_STATE_REPLAYABLE : s;
            lsu_pkg::LQ_STATE_MHQ_FILL_WAIT:
                return f.en ? lsu_pkg::LQ_STATE_REPLAYABLE : s;
            lsu_pkg::LQ_STATE_REPLAYABLE:
                return grant ? lsu_pkg::LQ_STATE_LAUNCHED : s;
            lsu_pkg::LQ_STATE_COMPLETE:
                return retire_hit ? lsu_pkg::LQ_STATE_INVALID : s;
            default:
                return lsu_pkg::LQ_STATE_INVALID;
        endcase
    endfunction

    task automatic check(string name, logic [63:0] exp, logic [63:0] act);
        o_checks++;
        if (exp !== act) begin
            o_errors++;
            $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    always @(posedge clk) begin : compare
        logic                exp_full;
        logic                rep_valid;
        logic                exp_ack;
        logic                exp_ms;
        int                  exp_alloc;
        int                  exp_rep;
        lsu_pkg::lq_replay_t exp_load;
        logic                alloc_hit;
        logic                upd_hit;
        logic                grant;
        logic                ret_hit;
        logic                executed;
        lsu_pkg::lq_state_t  nxt;

        if (i_reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                st[i] = lsu_pkg::LQ_STATE_INVALID;
                ms[i] = 1'b0;
            end
            ptr      = 0;
            o_errors = 0;
            o_checks = 0;
        end else begin
            exp_full  = 1'b1;
            exp_alloc = 0;
            for (int i = DEPTH - 1; i >= 0; i--) begin
                if (st[i] == lsu_pkg::LQ_STATE_INVALID) begin
                    exp_full  = 1'b0;
                    exp_alloc = i;
                end
            end
            // Replay candidate searched upward from the round-robin pointer
            rep_valid = 1'b0;
            exp_rep   = 0;
            for (int k = 0; k < DEPTH; k++) begin
                if (!rep_valid && st[(ptr + k) % DEPTH] == lsu_pkg::LQ_STATE_REPLAYABLE) begin
                    rep_valid = 1'b1;
                    exp_rep   = (ptr + k) % DEPTH;
                end
            end
            exp_load = '0;
            if (rep_valid) begin
                exp_load.valid = 1'b1;
                exp_load.func  = fn[exp_rep];
                exp_load.tag   = tg[exp_rep];
                exp_load.addr  = ad[exp_rep];
            end
            exp_ack = 1'b0;
            exp_ms  = 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                if (i_rob_retire.en && st[i] == lsu_pkg::LQ_STATE_COMPLETE &&
                    tg[i] == i_rob_retire.tag) begin
                    exp_ack = 1'b1;
                    exp_ms  = ms[i];
                end
            end

            check("o_full", 64'(exp_full), 64'(i_full));
            if (!exp_full) check("o_alloc_idx", 64'(exp_alloc), 64'(i_alloc_idx));
            check("o_replay", 64'(exp_load), 64'(i_replay));
            if (rep_valid) check("o_replay_idx", 64'(exp_rep), 64'(i_replay_idx));
            check("o_retire_ack", 64'(exp_ack), 64'(i_retire_ack));
            check("o_retire_misspeculated", 64'(exp_ms), 64'(i_retire_misspec));

            // Advance the model by one cycle
            for (int i = 0; i < DEPTH; i++) begin
                alloc_hit = i_alloc.en && !exp_full && exp_alloc == i;
                upd_hit   = i_update.en && int'(i_update.lq_idx) == i;
                grant     = rep_valid && !i_replay_stall && exp_rep == i;
                ret_hit   = i_rob_retire.en && st[i] == lsu_pkg::LQ_STATE_COMPLETE &&
                            tg[i] == i_rob_retire.tag;
                executed  = st[i] == lsu_pkg::LQ_STATE_VALID ||
                            st[i] == lsu_pkg::LQ_STATE_LAUNCHED ||
                            st[i] == lsu_pkg::LQ_STATE_COMPLETE;
                ms[i] = executed && (ms[i] || hits_store(ad[i], fn[i], i_sq_retire));
                nxt = step_state(st[i], alloc_hit, upd_hit, i_update, i_mhq_fill, mt[i],
                                 grant, ret_hit, i_flush);
                if (alloc_hit) begin
                    fn[i] = i_alloc.func;
                    tg[i] = i_alloc.tag;
                    ad[i] = i_alloc.addr;
                end
                if (upd_hit) mt[i] = i_update.mhq_tag;
                st[i] = nxt;
            end
            if (i_flush) ptr = 0;
            else if (rep_valid && !i_replay_stall) ptr = (exp_rep + 1) % DEPTH;
        end
    end

endmodule

`default_nettype wire

//--- verilog/lsu_lq.sv
// Load queue top, tracks in-flight loads between allocation and reorder buffer retirement
`default_nettype none

`include "lsu_params.svh"

module lsu_lq (
    input  logic                            clk,
    input  logic                            i_reset,
    input  logic                            i_flush,
    input  lsu_pkg::lq_alloc_t              i_alloc,
    input  lsu_pkg::lq_update_t             i_update,
    input  lsu_pkg::mhq_fill_t              i_mhq_fill,
    input  lsu_pkg::sq_retire_t             i_sq_retire,
    input  lsu_pkg::rob_retire_t            i_rob_retire,
    input  logic                            i_replay_stall,
    output logic                            o_full,
    output logic [`LSU_LQ_IDX_WIDTH-1:0]    o_alloc_idx,
    output lsu_pkg::lq_replay_t             o_replay,
    output logic [`LSU_LQ_IDX_WIDTH-1:0]    o_replay_idx,
    output logic                            o_retire_ack,
    output logic                            o_retire_misspeculated
);

    localparam int DEPTH = `LSU_LQ_DEPTH;
    localparam int IDX_W = `LSU_LQ_IDX_WIDTH;

    logic [DEPTH-1:0]       alloc_en;
    logic [DEPTH-1:0]       update_en;
    logic [DEPTH-1:0]       replay_grant;
    logic [DEPTH-1:0]       entry_empty;
    logic [DEPTH-1:0]       entry_replayable;
    logic [DEPTH-1:0]       entry_ack;
    logic [DEPTH-1:0]       entry_misspec;
    lsu_pkg::lq_replay_t    entry_load [DEPTH];
    logic                   replay_valid;

    genvar g;
    generate
        for (g = 0; g < DEPTH; g++) begin : g_entry
            // Requests seen while full are dropped
            assign alloc_en[g]  = i_alloc.en & ~o_full & (o_alloc_idx == IDX_W'(g));
            assign update_en[g] = i_update.en & (i_update.lq_idx == IDX_W'(g));

            lsu_lq_entry entry0 (
                .clk             (clk),
                .i_reset         (i_reset),
                .i_flush         (i_flush),
                .i_alloc_en      (alloc_en[g]),
                .i_alloc         (i_alloc),
                .i_update_en     (update_en[g]),
                .i_update        (i_update),
                .i_mhq_fill      (i_mhq_fill),
                .i_sq_retire     (i_sq_retire),
                .i_replay_grant  (replay_grant[g]),
                .i_rob_retire    (i_rob_retire),
                .o_empty         (entry_empty[g]),
                .o_replayable    (entry_replayable[g]),
                .o_load          (entry_load[g]),
                .o_retire_ack    (entry_ack[g]),
                .o_misspeculated (entry_misspec[g])
            );
        end
    endgenerate

    lsu_lq_select select0 (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_flush        (i_flush),
        .i_empty        (entry_empty),
        .i_replayable   (entry_replayable),
        .i_replay_stall (i_replay_stall),
        .o_full         (o_full),
        .o_alloc_idx    (o_alloc_idx),
        .o_replay_valid (replay_valid),
        .o_replay_idx   (o_replay_idx),
        .o_replay_grant (replay_grant)
    );

    // The offer follows the selected slot, not the grant, so it stays up under stall
    always_comb begin
        o_replay = '0;
        if (replay_valid) begin
            o_replay       = entry_load[o_replay_idx];
            o_replay.valid = 1'b1;
        end
    end

    // Reorder buffer tags are unique, so at most one slot answers a retirement
    assign o_retire_ack           = |entry_ack;
    assign o_retire_misspeculated = |(entry_ack & entry_misspec);

endmodule

`default_nettype wire

//--- verilog/lsu_lq_select.sv
// Allocation and replay pickers of the load queue, fed with the per-entry status bits
`default_nettype none

`include "lsu_params.svh"

module lsu_lq_select (
    input  logic                            clk,
    input  logic                            i_reset,
    input  logic                            i_flush,
    input  logic [`LSU_LQ_DEPTH-1:0]        i_empty,
    input  logic [`LSU_LQ_DEPTH-1:0]        i_replayable,
    input  logic                            i_replay_stall,
    output logic                            o_full,
    output logic [`LSU_LQ_IDX_WIDTH-1:0]    o_alloc_idx,
    output logic                            o_replay_valid,
    output logic [`LSU_LQ_IDX_WIDTH-1:0]    o_replay_idx,
    output logic [`LSU_LQ_DEPTH-1:0]        o_replay_grant
);

    localparam int DEPTH = `LSU_LQ_DEPTH;
    localparam int IDX_W = `LSU_LQ_IDX_WIDTH;

    logic [IDX_W-1:0] replay_ptr_r;
    logic             replay_take;

    assign o_full = ~|i_empty;

    // Walking down from the top leaves the lowest empty slot as the winner
    always_comb begin
        o_alloc_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (i_empty[i]) o_alloc_idx = IDX_W'(i);
        end
    end

    // First replayable slot at or above the pointer, wrapping round the queue
    always_comb begin
        logic [IDX_W-1:0] cand;
        logic             found;

        found        = 1'b0;
        o_replay_idx = '0;
        for (int k = 0; k < DEPTH; k++) begin
            cand = IDX_W'((int'(replay_ptr_r) + k) % DEPTH);
            if (!found && i_replayable[cand]) begin
                found        = 1'b1;
                o_replay_idx = cand;
            end
        end
        o_replay_valid = found;
    end

    // Stall keeps the offer in place and holds the pointer
    assign replay_take    = o_replay_valid & ~i_replay_stall;
    assign o_replay_grant = replay_take ? (DEPTH'(1) << o_replay_idx) : '0;

    // Pointer moves past the granted slot so every waiting load gets its turn
    always_ff @(posedge clk) begin
        if (i_reset | i_flush) begin
            replay_ptr_r <= '0;
        end else if (replay_take) begin
            replay_ptr_r <= IDX_W'((int'(o_replay_idx) + 1) % DEPTH);
        end
    end

endmodule

`default_nettype wire

//--- verilog/lsu_lq_entry.sv
// One load queue entry with its state machine, instantiated once per slot by the load queue top
`default_nettype none

`include "lsu_params.svh"

module lsu_lq_entry (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_flush,
    input  logic                   i_alloc_en,
    input  lsu_pkg::lq_alloc_t     i_alloc,
    input  logic                   i_update_en,
    input  lsu_pkg::lq_update_t    i_update,
    input  lsu_pkg::mhq_fill_t     i_mhq_fill,
    input  lsu_pkg::sq_retire_t    i_sq_retire,
    input  logic                   i_replay_grant,
    input  lsu_pkg::rob_retire_t   i_rob_retire,
    output logic                   o_empty,
    output logic                   o_replayable,
    output lsu_pkg::lq_replay_t    o_load,
    output logic                   o_retire_ack,
    output logic                   o_misspeculated
);

    localparam int ADDR_W    = `LSU_ADDR_WIDTH;
    localparam int WORD_SIZE = `LSU_DATA_WIDTH / 8;

    lsu_pkg::lq_state_t                state_r;
    lsu_pkg::lq_state_t                state_next;
    lsu_pkg::lsu_func_t                func_r;
    logic [`LSU_ROB_IDX_WIDTH-1:0]     tag_r;
    logic [`LSU_ADDR_WIDTH-1:0]        addr_r;
    logic [`LSU_MHQ_IDX_WIDTH-1:0]     mhq_tag_r;
    logic                              misspec_r;
    logic                              misspec_next;
    logic                              retire_en;

    // Only a completed load with the matching reorder buffer tag retires
    assign retire_en = i_rob_retire.en & (i_rob_retire.tag == tag_r) &
                       (state_r == lsu_pkg::LQ_STATE_COMPLETE);

    always_comb begin
        lsu_pkg::lq_state_t update_state;
        logic               fill_hit;

        // A parked miss wakes when the fill carries the tag it is waiting on
        fill_hit = i_mhq_fill.en & (i_mhq_fill.tag == mhq_tag_r);

        // Where an update sends the load
        // A fill in the same cycle as a retry update is caught here, otherwise it would be missed
        if (i_update.replay | i_update.mhq_replay) begin
            update_state = lsu_pkg::LQ_STATE_REPLAYABLE;
        end else if (i_update.retry & i_update.mhq_retry) begin
            update_state = i_mhq_fill.en ? lsu_pkg::LQ_STATE_REPLAYABLE
                                         : lsu_pkg::LQ_STATE_MHQ_FILL_WAIT;
        end else if (i_update.retry) begin
            update_state = (i_mhq_fill.en & (i_mhq_fill.tag == i_update.mhq_tag))
                         ? lsu_pkg::LQ_STATE_REPLAYABLE : lsu_pkg::LQ_STATE_MHQ_TAG_WAIT;
        end else begin
            update_state = lsu_pkg::LQ_STATE_COMPLETE;
        end

        state_next = state_r;
        case (state_r)
            lsu_pkg::LQ_STATE_INVALID: begin
                if (i_alloc_en) state_next = lsu_pkg::LQ_STATE_VALID;
            end
            lsu_pkg::LQ_STATE_VALID,
            lsu_pkg::LQ_STATE_LAUNCHED: begin
                if (i_update_en) state_next = update_state;
            end
            lsu_pkg::LQ_STATE_MHQ_TAG_WAIT: begin
                if (fill_hit) state_next = lsu_pkg::LQ_STATE_REPLAYABLE;
            end
            lsu_pkg::LQ_STATE_MHQ_FILL_WAIT: begin
                // Any fill may free the resource this load was short of
                if (i_mhq_fill.en) state_next = lsu_pkg::LQ_STATE_REPLAYABLE;
            end
            lsu_pkg::LQ_STATE_REPLAYABLE: begin
                if (i_replay_grant) state_next = lsu_pkg::LQ_STATE_LAUNCHED;
            end
            lsu_pkg::LQ_STATE_COMPLETE: begin
                if (retire_en) state_next = lsu_pkg::LQ_STATE_INVALID;
            end
            default: state_next = lsu_pkg::LQ_STATE_INVALID;
        endcase

        if (i_flush) state_next = lsu_pkg::LQ_STATE_INVALID;
    end

    always_comb begin
        logic [`LSU_ADDR_WIDTH-1:0] load_end;
        logic                       overlap;
        logic                       executed;

        // Exclusive end of the bytes this load reads
        case (func_r)
            lsu_pkg::LSU_FUNC_LB,
            lsu_pkg::LSU_FUNC_LBU: load_end = addr_r + ADDR_W'(1);
            lsu_pkg::LSU_FUNC_LH,
            lsu_pkg::LSU_FUNC_LHU: load_end = addr_r + ADDR_W'(WORD_SIZE / 2);
            default:               load_end = addr_r + ADDR_W'(WORD_SIZE);
        endcase

        // Either range starting inside the other means they share a byte
        overlap = i_sq_retire.en &
                  (((addr_r >= i_sq_retire.addr) & (addr_r < i_sq_retire.addr_end)) |
                   ((i_sq_retire.addr >= addr_r) & (i_sq_retire.addr < load_end)));

        // Only a load that may have read memory can have read stale data
        // Waiting loads will read again, and an empty slot has nothing, so the flag drops there
        executed = (state_r == lsu_pkg::LQ_STATE_VALID) |
                   (state_r == lsu_pkg::LQ_STATE_LAUNCHED) |
                   (state_r == lsu_pkg::LQ_STATE_COMPLETE);
        misspec_next = executed & (misspec_r | overlap);
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_r   <= lsu_pkg::LQ_STATE_INVALID;
            misspec_r <= 1'b0;
        end else begin
            state_r   <= state_next;
            misspec_r <= misspec_next;
        end
    end

    // Load fields are captured once at allocation
    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            func_r <= i_alloc.func;
            tag_r  <= i_alloc.tag;
            addr_r <= i_alloc.addr;
        end
    end

    // The miss tag follows every update addressed to this slot
    always_ff @(posedge clk) begin
        if (i_update_en) mhq_tag_r <= i_update.mhq_tag;
    end

    assign o_empty         = (state_r == lsu_pkg::LQ_STATE_INVALID);
    assign o_replayable    = (state_r == lsu_pkg::LQ_STATE_REPLAYABLE);
    assign o_load.valid    = o_replayable;
    assign o_load.func     = func_r;
    assign o_load.tag      = tag_r;
    assign o_load.addr     = addr_r;
    assign o_retire_ack    = retire_en;
    assign o_misspeculated = misspec_r;

endmodule

`default_nettype wire

//--- verilog/lsu_pkg.sv
// Shared load queue types: load function codes, entry states and the port structs of the queue
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

    // Load kinds, the signed and unsigned variants only differ in data return
    typedef enum logic [2:0] {
        LSU_FUNC_LB  = 3'b000,
        LSU_FUNC_LH  = 3'b001,
        LSU_FUNC_LW  = 3'b010,
        LSU_FUNC_LBU = 3'b011,
        LSU_FUNC_LHU = 3'b100
    } lsu_func_t;

    // Life cycle of one load queue entry
    // VALID and LAUNCHED both mean the load is in the pipeline waiting for an update
    // The two WAIT states are cache misses parked until the miss handling queue fills a line
    typedef enum logic [2:0] {
        LQ_STATE_INVALID       = 3'b000,
        LQ_STATE_VALID         = 3'b001,
        LQ_STATE_MHQ_TAG_WAIT  = 3'b010,
        LQ_STATE_MHQ_FILL_WAIT = 3'b011,
        LQ_STATE_REPLAYABLE    = 3'b100,
        LQ_STATE_LAUNCHED      = 3'b101,
        LQ_STATE_COMPLETE      = 3'b110
    } lq_state_t;

    // New load from the issue stage
    typedef struct packed {
        logic                             en;
        lsu_func_t                        func;
        logic [`LSU_ROB_IDX_WIDTH-1:0]    tag;
        logic [`LSU_ADDR_WIDTH-1:0]       addr;
    } lq_alloc_t;

    // Outcome of a load from the execute stage and the miss handling queue lookup
    typedef struct packed {
        logic                             en;
        logic [`LSU_LQ_IDX_WIDTH-1:0]     lq_idx;
        logic                             retry;
        logic                             replay;
        logic [`LSU_MHQ_IDX_WIDTH-1:0]    mhq_tag;
        logic                             mhq_retry;
        logic                             mhq_replay;
    } lq_update_t;

    // Fill broadcast from the miss handling queue
    typedef struct packed {
        logic                             en;
        logic [`LSU_MHQ_IDX_WIDTH-1:0]    tag;
    } mhq_fill_t;

    // Byte range of a retiring store, addr_end is exclusive
    typedef struct packed {
        logic                             en;
        logic [`LSU_ADDR_WIDTH-1:0]       addr;
        logic [`LSU_ADDR_WIDTH-1:0]       addr_end;
    } sq_retire_t;

    // Reorder buffer retirement of a load
    typedef struct packed {
        logic                             en;
        logic [`LSU_ROB_IDX_WIDTH-1:0]    tag;
    } rob_retire_t;

    // Load sent back into the pipeline
    typedef struct packed {
        logic                             valid;
        lsu_func_t                        func;
        logic [`LSU_ROB_IDX_WIDTH-1:0]    tag;
        logic [`LSU_ADDR_WIDTH-1:0]       addr;
    } lq_replay_t;

endpackage

`default_nettype wire

//--- verilog/lsu_params.svh
// Load queue sizing and field widths, included by every load queue source that needs them
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Number of load queue entries
`define LSU_LQ_DEPTH 8

// Width of an entry index, log2 of the depth
`define LSU_LQ_IDX_WIDTH 3

// Load and store address width
`define LSU_ADDR_WIDTH 32

// Data word width, a full word load covers LSU_DATA_WIDTH/8 bytes
`define LSU_DATA_WIDTH 32

// Reorder buffer tag and miss handling queue tag widths
`define LSU_ROB_IDX_WIDTH 5
`define LSU_MHQ_IDX_WIDTH 2

`endif
